/* spi_pkg.sv */
`default_nettype none

package spi_pkg;

   //####################
   // Emesh bus
   //####################

   // Address width of dstaddr and srcaddr
   localparam int AW = 32;
   // Full packet width
   localparam int PW = 104;

   //####################
   // SPI link
   //####################

   // Byte registers in the slave
   localparam int SREGS = 40;
   // clk cycles per sclk half period
   localparam int SPI_CLKDIV = 2;
   localparam int FRAME_BITS = 16;

   // Frame layout, MSB first on the wire
   localparam int READ_BIT = 15;
   localparam int ADDR_MSB = 14;
   localparam int ADDR_LSB = 8;
   localparam int DATA_MSB = 7;

   // Header is the read flag plus register index
   localparam int HDR_BITS = FRAME_BITS - ADDR_LSB;
   localparam int REG_AW   = ADDR_MSB - ADDR_LSB + 1;

   // Counter widths
   localparam int DIV_W = (SPI_CLKDIV > 1) ? $clog2(SPI_CLKDIV) : 1;
   localparam int BIT_W = $clog2(FRAME_BITS);

   // Master controller states
   localparam logic [1:0] M_IDLE = 2'd0;
   localparam logic [1:0] M_BUSY = 2'd1;
   localparam logic [1:0] M_RESP = 2'd2;

   //####################
   // Packet views
   //####################

   // Write request, write bit in bit 0
   typedef struct packed {
      logic [AW-1:0] data_hi;
      logic [AW-1:0] data;
      logic [AW-1:0] dstaddr;
      logic [4:0]    ctrlmode;
      logic [1:0]    datamode;
      logic          write;
   } emesh_write_t;

   // Read request, top word is the return address
   typedef struct packed {
      logic [AW-1:0] srcaddr;
      logic [AW-1:0] reserved;
      logic [AW-1:0] dstaddr;
      logic [4:0]    ctrlmode;
      logic [1:0]    datamode;
      logic          write;
   } emesh_read_t;

   // Same word, two decodings
   typedef union packed {
      emesh_write_t wr;
      emesh_read_t  rd;
   } emesh_packet_t;

endpackage

`default_nettype wire

/* spi_master_io.sv */
`timescale 1ns/1ns
`default_nettype none

module spi_master_io (
   input  logic                           clk,
   input  logic                           reset,
   // Frame request and completion
   input  logic                           start,
   input  logic [spi_pkg::FRAME_BITS-1:0] frame,
   output logic                           done,
   output logic [7:0]                     rx_byte,
   // SPI pins, mode 0
   output logic                           sclk,
   output logic                           mosi,
   output logic                           ss,
   input  logic                           miso
);
   import spi_pkg::*;

   logic [DIV_W-1:0]      div_cnt;
   logic [BIT_W-1:0]      bit_cnt;
   logic [FRAME_BITS-1:0] tx_shift;
   logic                  stop;
   logic                  ss_rose;
   logic                  running;
   logic                  tick;
   logic                  sclk_rise;
   logic                  sclk_fall;

   // sclk runs only while ss is low and the frame is not closing
   assign running   = ~ss & ~stop;
   assign tick      = running && (div_cnt == DIV_W'(SPI_CLKDIV - 1));
   assign sclk_rise = tick & ~sclk;
   assign sclk_fall = tick & sclk;
   // MSB first
   assign mosi      = tx_shift[FRAME_BITS-1];

   //####################
   // Clock and framing
   //####################
   always_ff @(posedge clk) begin
      if (reset) begin
         ss      <= 1'b1;
         sclk    <= 1'b0;
         stop    <= 1'b0;
         ss_rose <= 1'b0;
         done    <= 1'b0;
         div_cnt <= '0;
         bit_cnt <= '0;
      end else begin
         ss_rose <= 1'b0;
         // done trails the ss rise by a cycle
         done    <= ss_rose;
         if (ss) begin
            if (start) begin
               ss      <= 1'b0;
               div_cnt <= '0;
               bit_cnt <= '0;
            end
         end else if (stop) begin
            ss      <= 1'b1;
            stop    <= 1'b0;
            ss_rose <= 1'b1;
         end else begin
            if (tick) begin
               div_cnt <= '0;
               sclk    <= ~sclk;
            end else begin
               div_cnt <= div_cnt + 1'b1;
            end
            // Count bits on falling edges
            if (sclk_fall) begin
               bit_cnt <= bit_cnt + 1'b1;
               if (bit_cnt == BIT_W'(FRAME_BITS - 1)) begin
                  stop <= 1'b1;
               end
            end
         end
      end
   end

   //####################
   // Data shifting
   //####################
   always_ff @(posedge clk) begin
      if (ss && start) begin
         tx_shift <= frame;
      end else if (sclk_fall) begin
         tx_shift <= {tx_shift[FRAME_BITS-2:0], 1'b0};
      end
      // Read byte arrives in the last eight bits
      if (sclk_rise && bit_cnt >= BIT_W'(HDR_BITS)) begin
         rx_byte <= {rx_byte[6:0], miso};
      end
   end

endmodule

`default_nettype wire

/* spi_master.sv */
`timescale 1ns/1ns
`default_nettype none

module spi_master (
   input  logic                   clk,
   input  logic                   reset,
   // Incoming requests
   input  logic                   access_in,
   input  spi_pkg::emesh_packet_t packet_in,
   output logic                   wait_out,
   // Read responses
   output logic                   access_out,
   output spi_pkg::emesh_packet_t packet_out,
   input  logic                   wait_in,
   // SPI pins
   output logic                   sclk,
   output logic                   mosi,
   output logic                   ss,
   input  logic                   miso
);
   import spi_pkg::*;

   logic [1:0]            state;
   logic                  accept;
   emesh_packet_t         req_q;
   emesh_packet_t         rsp;
   logic                  start;
   logic [FRAME_BITS-1:0] frame;
   logic                  done;
   logic [7:0]            rx_byte;

   // Take a packet only while not stalling
   assign accept = access_in & ~wait_out;

   //####################
   // Controller
   //####################
   always_ff @(posedge clk) begin
      if (reset) begin
         state      <= M_IDLE;
         wait_out   <= 1'b0;
         access_out <= 1'b0;
         start      <= 1'b0;
      end else begin
         start <= 1'b0;
         case (state)
            M_IDLE: begin
               if (accept) begin
                  state    <= M_BUSY;
                  wait_out <= 1'b1;
                  start    <= 1'b1;
               end
            end
            M_BUSY: begin
               // Frame finished on the wire
               if (done) begin
                  if (!req_q.rd.write) begin
                     state      <= M_RESP;
                     access_out <= 1'b1;
                  end else begin
                     state    <= M_IDLE;
                     wait_out <= 1'b0;
                  end
               end
            end
            M_RESP: begin
               // Response held until the receiver takes it
               if (!wait_in) begin
                  state      <= M_IDLE;
                  access_out <= 1'b0;
                  wait_out   <= 1'b0;
               end
            end
            default: begin
               state <= M_IDLE;
            end
         endcase
      end
   end

   // Response goes back to the requester
   always_comb begin
      rsp             = req_q;
      rsp.rd.write    = 1'b1;
      rsp.rd.dstaddr  = req_q.rd.srcaddr;
      rsp.rd.srcaddr  = req_q.rd.dstaddr;
      // Overlays the data word of the write view
      rsp.rd.reserved = AW'(rx_byte);
   end

   //####################
   // Request and response data
   //####################
   always_ff @(posedge clk) begin
      if (state == M_IDLE && accept) begin
         req_q <= packet_in;
         // Read flag, register index, data byte
         frame <= {~packet_in.rd.write,
                   packet_in.wr.dstaddr[REG_AW-1:0],
                   packet_in.wr.data[DATA_MSB:0]};
      end
      if (state == M_BUSY && done) begin
         packet_out <= rsp;
      end
   end

   spi_master_io spi_master_io_i (
      .clk     (clk),
      .reset   (reset),
      .start   (start),
      .frame   (frame),
      .done    (done),
      .rx_byte (rx_byte),
      .sclk    (sclk),
      .mosi    (mosi),
      .ss      (ss),
      .miso    (miso)
   );

endmodule

`default_nettype wire

/* spi_slave_io.sv */
`timescale 1ns/1ns
`default_nettype none

module spi_slave_io (
   input  logic                       clk,
   input  logic                       reset,
   // SPI pins
   input  logic                       sclk,
   input  logic                       mosi,
   input  logic                       ss,
   output logic                       miso,
   // Decoded frame
   output logic                       addr_valid,
   output logic                       rx_read,
   output logic [spi_pkg::REG_AW-1:0] rx_addr,
   output logic                       wr_strobe,
   output logic [7:0]                 rx_data,
   input  logic [7:0]                 tx_byte
);
   import spi_pkg::*;

   logic                  sclk_q;
   logic                  sclk_rise;
   logic                  sclk_fall;
   logic                  hdr_last;
   logic                  frame_last;
   logic [BIT_W-1:0]      bit_cnt;
   logic [FRAME_BITS-1:0] rx_shift;
   logic [FRAME_BITS-1:0] rx_next;
   logic [7:0]            tx_shift;

   // Edges of sclk, only inside a frame
   assign sclk_rise  = sclk & ~sclk_q & ~ss;
   assign sclk_fall  = ~sclk & sclk_q & ~ss;
   assign rx_next    = {rx_shift[FRAME_BITS-2:0], mosi};
   // Eighth and sixteenth sampled bit
   assign hdr_last   = sclk_rise && (bit_cnt == BIT_W'(HDR_BITS - 1));
   assign frame_last = sclk_rise && (bit_cnt == BIT_W'(FRAME_BITS - 1));
   assign miso       = tx_shift[7];

   //####################
   // Framing and strobes
   //####################
   always_ff @(posedge clk) begin
      if (reset) begin
         sclk_q     <= 1'b0;
         bit_cnt    <= '0;
         addr_valid <= 1'b0;
         wr_strobe  <= 1'b0;
         rx_read    <= 1'b0;
         tx_shift   <= 8'h00;
      end else begin
         sclk_q     <= sclk;
         addr_valid <= hdr_last;
         // Reads carry no write data
         wr_strobe  <= frame_last & ~rx_read;
         if (hdr_last) begin
            rx_read <= rx_next[READ_BIT - ADDR_LSB];
         end
         // ss high drops any partial frame
         if (ss) begin
            bit_cnt <= '0;
         end else if (sclk_rise) begin
            bit_cnt <= bit_cnt + 1'b1;
         end
         // Return byte on falling edges after the header
         if (ss) begin
            tx_shift <= 8'h00;
         end else if (sclk_fall) begin
            if (bit_cnt == BIT_W'(HDR_BITS)) begin
               tx_shift <= rx_read ? tx_byte : 8'h00;
            end else if (bit_cnt > BIT_W'(HDR_BITS)) begin
               tx_shift <= {tx_shift[6:0], 1'b0};
            end
         end
      end
   end

   //####################
   // Receive data
   //####################
   always_ff @(posedge clk) begin
      if (sclk_rise) begin
         rx_shift <= rx_next;
      end
      if (hdr_last) begin
         rx_addr <= rx_next[ADDR_MSB - ADDR_LSB:0];
      end
      if (frame_last) begin
         rx_data <= rx_next[DATA_MSB:0];
      end
   end

endmodule

`default_nettype wire

/* spi_slave.sv */
`timescale 1ns/1ns
`default_nettype none

module spi_slave (
   input  logic                         clk,
   input  logic                         reset,
   // SPI pins
   input  logic                         sclk,
   input  logic                         mosi,
   input  logic                         ss,
   output logic                         miso,
   // Whole register bank, register 0 lowest
   output logic [spi_pkg::SREGS*8-1:0]  spi_regs
);
   import spi_pkg::*;

   logic              addr_valid;
   logic              rx_read;
   logic [REG_AW-1:0] rx_addr;
   logic              wr_strobe;
   logic [7:0]        rx_data;
   logic [7:0]        tx_byte;
   logic [7:0]        rd_byte;
   logic              in_range;
   logic [7:0]        regs [SREGS];

   // Indices past the bank are ignored
   assign in_range = rx_addr < REG_AW'(SREGS);

   //####################
   // Register bank
   //####################
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < SREGS; i++) begin
            regs[i] <= 8'h00;
         end
      end else if (wr_strobe && in_range) begin
         for (int i = 0; i < SREGS; i++) begin
            if (rx_addr == REG_AW'(i)) begin
               regs[i] <= rx_data;
            end
         end
      end
   end

   // Read mux
   always_comb begin
      rd_byte = 8'h00;
      for (int i = 0; i < SREGS; i++) begin
         if (rx_addr == REG_AW'(i)) begin
            rd_byte = regs[i];
         end
      end
   end

   // Byte to return, ready before the first data bit leaves
   always_ff @(posedge clk) begin
      if (addr_valid && rx_read) begin
         tx_byte <= in_range ? rd_byte : 8'h00;
      end
   end

   // Flat view
   for (genvar g = 0; g < SREGS; g++) begin : g_flat
      assign spi_regs[g*8 +: 8] = regs[g];
   end

   //####################
   // Bit level
   //####################
   spi_slave_io spi_slave_io_i (
      .clk        (clk),
      .reset      (reset),
      .sclk       (sclk),
      .mosi       (mosi),
      .ss         (ss),
      .miso       (miso),
      .addr_valid (addr_valid),
      .rx_read    (rx_read),
      .rx_addr    (rx_addr),
      .wr_strobe  (wr_strobe),
      .rx_data    (rx_data),
      .tx_byte    (tx_byte)
   );

endmodule

`default_nettype wire

/* spi_loopback.sv */
`timescale 1ns/1ns
`default_nettype none

module spi_loopback (
   input  logic                        clk,
   input  logic                        reset,
   // Stimulus driven transaction
   input  logic                        access_in,
   input  spi_pkg::emesh_packet_t      packet_in,
   output logic                        wait_out,
   // DUT driven transaction
   output logic                        access_out,
   output spi_pkg::emesh_packet_t      packet_out,
   input  logic                        wait_in,
   // Slave register bank
   output logic [spi_pkg::SREGS*8-1:0] spi_regs
);

   // SPI link between the two halves
   logic sclk;
   logic mosi;
   logic miso;
   logic ss;

   //####################
   // Emesh side master
   //####################
   spi_master spi_master_i (
      .clk        (clk),
      .reset      (reset),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_in    (wait_in),
      .sclk       (sclk),
      .mosi       (mosi),
      .ss         (ss),
      .miso       (miso)
   );

   //####################
   // Register slave
   //####################
   spi_slave spi_slave_i (
      .clk      (clk),
      .reset    (reset),
      .sclk     (sclk),
      .mosi     (mosi),
      .ss       (ss),
      .miso     (miso),
      .spi_regs (spi_regs)
   );

endmodule

`default_nettype wire

/* spi_loopback_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

module spi_loopback_assertions (
   input  logic clk,
   input  logic reset,
   input  logic sclk,
   input  logic mosi,
   input  logic ss,
   input  logic addr_valid,
   input  logic wr_strobe
);
   import spi_pkg::*;

   logic sclk_d;
   logic first_bit;
   logic frame_rd;

   //####################
   // Frame type from the wire
   //####################

   // First bit sampled in a frame is the read flag
   always_ff @(posedge clk) begin
      if (reset) begin
         sclk_d    <= 1'b0;
         first_bit <= 1'b1;
         frame_rd  <= 1'b0;
      end else begin
         sclk_d <= sclk;
         if (ss) begin
            first_bit <= 1'b1;
         end else if (sclk && !sclk_d) begin
            first_bit <= 1'b0;
            if (first_bit) begin
               frame_rd <= mosi;
            end
         end
      end
   end

   //####################
   // SPI framing
   //####################

   // Any sclk edge falls inside a frame
   a_sclk_in_frame : assert property (
      @(posedge clk) disable iff (reset)
      (sclk != $past(sclk)) |-> (!ss && !$past(ss))
   ) else $error("sclk toggled while ss was high");

   //####################
   // Slave strobes
   //####################

   // Data strobe trails the header strobe by eight bits
   a_strobes_apart : assert property (
      @(posedge clk) disable iff (reset)
      wr_strobe |-> (!addr_valid &&
                     $past(addr_valid, (FRAME_BITS - HDR_BITS) * 2 * SPI_CLKDIV))
   ) else $error("addr_valid and wr_strobe not eight bits apart");

   // Read frames must not touch the bank
   a_no_write_on_read : assert property (
      @(posedge clk) disable iff (reset)
      wr_strobe |-> !frame_rd
   ) else $error("wr_strobe raised in a read frame");

endmodule

// Checker sits on the slave bit level
bind spi_slave_io spi_loopback_assertions spi_loopback_assertions_i (
   .clk        (clk),
   .reset      (reset),
   .sclk       (sclk),
   .mosi       (mosi),
   .ss         (ss),
   .addr_valid (addr_valid),
   .wr_strobe  (wr_strobe)
);

`default_nettype wire

/* spi_loopback_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module spi_loopback_tb;
   import spi_pkg::*;

   // Frame bits plus start, ss rise, done and controller cycles
   localparam int ACCEPT_LAT = 2 * SPI_CLKDIV * FRAME_BITS + 4;
   localparam int NUM_TESTS  = 24;

   logic               clk       = 1'b0;
   logic               reset     = 1'b1;
   logic               access_in = 1'b0;
   emesh_packet_t      packet_in = '0;
   logic               wait_in   = 1'b0;
   logic               wait_out;
   logic               access_out;
   emesh_packet_t      packet_out;
   logic [SREGS*8-1:0] spi_regs;

   // Stimulus table, expected read byte and bank image per entry
   logic               t_read [NUM_TESTS];
   logic [6:0]         t_idx  [NUM_TESTS];
   logic [31:0]        t_data [NUM_TESTS];
   logic [31:0]        t_src  [NUM_TESTS];
   int                 t_bp   [NUM_TESTS];
   logic [7:0]         t_exp  [NUM_TESTS];
   logic [SREGS*8-1:0] t_regs [NUM_TESTS];

   int err_count   = 0;
   int check_count = 0;
   int rsp_count   = 0;
   int cycle_count = 0;
   int cycle_limit = 0;
   int max_bp      = 0;

   spi_loopback dut_i (
      .clk        (clk),
      .reset      (reset),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_in    (wait_in),
      .spi_regs   (spi_regs)
   );

   initial begin
      forever #4 clk = ~clk;
   end

   //####################
   // Watchdog and monitor
   //####################
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
         $display("Timeout after %0d cycles, the DUT stopped finishing transfers", cycle_count);
         $display("Checks failed");
         $finish;
      end
   end

   // Response taken on the next edge
   always @(negedge clk) begin
      if (!reset && access_out && !wait_in) begin
         rsp_count++;
      end
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Write view for writes, read view for reads
   function automatic emesh_packet_t make_request(input logic rd, input logic [6:0] idx,
                                                  input logic [31:0] data,
                                                  input logic [31:0] src);
      emesh_packet_t p;
      p = '0;
      if (rd) begin
         p.rd.dstaddr = {25'd0, idx};
         p.rd.srcaddr = src;
      end else begin
         p.wr.write   = 1'b1;
         p.wr.dstaddr = {25'd0, idx};
         p.wr.data    = data;
      end
      return p;
   endfunction

   // Response goes to the source address, byte in the data word
   function automatic emesh_packet_t make_response(input logic [31:0] src,
                                                   input logic [7:0] b);
      emesh_packet_t p;
      p            = '0;
      p.rd.write   = 1'b1;
      p.rd.dstaddr = src;
      p.wr.data    = {24'd0, b};
      return p;
   endfunction

   //####################
   // Compare tasks
   //####################
   task automatic check_bit(input string name, input logic exp, input logic act);
      check_count++;
      if (act !== exp) begin
         err_count++;
         $display("ERR %0t %0s expected %0b got %0b", $time, name, exp, act);
      end
   endtask

   task automatic check_regs(input string name, input logic [SREGS*8-1:0] exp,
                             input logic [SREGS*8-1:0] act);
      check_count++;
      if (act !== exp) begin
         err_count++;
         $display("ERR %0t %0s expected %h got %h", $time, name, exp, act);
      end
   endtask

   task automatic check_packet(input string name, input emesh_packet_t exp,
                               input emesh_packet_t act);
      check_count++;
      if (act.rd.dstaddr !== exp.rd.dstaddr) begin
         err_count++;
         $display("ERR %0t %0s.dstaddr expected %h got %h", $time, name,
                  exp.rd.dstaddr, act.rd.dstaddr);
      end
      if (act.wr.data !== exp.wr.data) begin
         err_count++;
         $display("ERR %0t %0s.data expected %h got %h", $time, name,
                  exp.wr.data, act.wr.data);
      end
   endtask

   //####################
   // Table setup
   //####################
   task automatic set_entry(input int i, input logic rd, input logic [6:0] idx,
                            input logic [31:0] data, input logic [31:0] src, input int bp);
      t_read[i] = rd;
      t_idx[i]  = idx;
      t_data[i] = data;
      t_src[i]  = src;
      t_bp[i]   = bp;
   endtask

   task automatic build_table();
      logic [31:0] rng;
      logic [7:0]  model [SREGS];
      logic [6:0]  idx;
      int          ix;
      rng = 32'd75;
      // Write then read back, random in-range index
      for (int p = 0; p < 8; p++) begin
         rng = xorshift32(rng);
         idx = 7'(rng % 32'(SREGS));
         rng = xorshift32(rng);
         set_entry(2 * p, 1'b0, idx, rng, 32'h0, 0);
         rng = xorshift32(rng);
         set_entry(2 * p + 1, 1'b1, idx, 32'h0, rng, (p % 3) * 3);
      end
      // Past the bank
      rng = xorshift32(rng);
      set_entry(16, 1'b0, 7'(SREGS), rng, 32'h0, 0);
      rng = xorshift32(rng);
      set_entry(17, 1'b0, 7'h7f, rng, 32'h0, 0);
      rng = xorshift32(rng);
      set_entry(18, 1'b1, 7'(SREGS), 32'h0, rng, 2);
      rng = xorshift32(rng);
      set_entry(19, 1'b1, 7'h7f, 32'h0, rng, 0);
      // Overwrite, reread, stray reads
      rng = xorshift32(rng);
      set_entry(20, 1'b0, t_idx[0], rng, 32'h0, 0);
      rng = xorshift32(rng);
      set_entry(21, 1'b1, t_idx[0], 32'h0, rng, 4);
      rng = xorshift32(rng);
      idx = 7'(rng % 32'(SREGS));
      rng = xorshift32(rng);
      set_entry(22, 1'b1, idx, 32'h0, rng, 1);
      rng = xorshift32(rng);
      set_entry(23, 1'b1, t_idx[6], 32'h0, rng, 7);
      // Reference bank, zero after reset
      for (int r = 0; r < SREGS; r++) begin
         model[r] = 8'h00;
      end
      for (int i = 0; i < NUM_TESTS; i++) begin
         ix = int'(t_idx[i]);
         if (!t_read[i] && ix < SREGS) begin
            model[ix] = t_data[i][7:0];
         end
         t_exp[i] = 8'h00;
         if (ix < SREGS) begin
            t_exp[i] = model[ix];
         end
         for (int r = 0; r < SREGS; r++) begin
            t_regs[i][r*8 +: 8] = model[r];
         end
         if (t_bp[i] > max_bp) begin
            max_bp = t_bp[i];
         end
      end
   endtask

   //####################
   // One table entry
   //####################
   task automatic run_entry(input int i);
      int            lat;
      int            errs_before;
      int            rsp_before;
      int            rsp_exp;
      string         kind;
      string         verdict;
      emesh_packet_t exp_pkt;
      errs_before = err_count;
      rsp_before  = rsp_count;
      exp_pkt     = make_response(t_src[i], t_exp[i]);
      lat         = 0;
      @(posedge clk);
      access_in <= 1'b1;
      packet_in <= make_request(t_read[i], t_idx[i], t_data[i], t_src[i]);
      wait_in   <= t_read[i] && (t_bp[i] > 0);
      // Acceptance edge
      @(posedge clk);
      access_in <= 1'b0;
      @(negedge clk);
      check_bit("wait_out", 1'b1, wait_out);
      if (!t_read[i]) begin
         while (wait_out) begin
            @(posedge clk);
            lat++;
            @(negedge clk);
         end
         check_bit("access_out", 1'b0, access_out);
      end else begin
         while (!access_out) begin
            @(posedge clk);
            lat++;
            @(negedge clk);
         end
         check_packet("packet_out", exp_pkt, packet_out);
         // Response must hold under back-pressure
         for (int k = 0; k < t_bp[i]; k++) begin
            @(posedge clk);
            if (k == t_bp[i] - 1) begin
               wait_in <= 1'b0;
            end
            @(negedge clk);
            check_bit("access_out", 1'b1, access_out);
            check_bit("wait_out", 1'b1, wait_out);
            check_packet("packet_out", exp_pkt, packet_out);
         end
         @(posedge clk);
         @(negedge clk);
         check_bit("access_out", 1'b0, access_out);
         check_bit("wait_out", 1'b0, wait_out);
      end
      check_regs("spi_regs", t_regs[i], spi_regs);
      if (lat != ACCEPT_LAT) begin
         err_count++;
         $display("Test %0d took %0d cycles from acceptance, not %0d", i, lat, ACCEPT_LAT);
      end
      rsp_exp = t_read[i] ? 1 : 0;
      if (rsp_count - rsp_before != rsp_exp) begin
         err_count++;
         $display("Test %0d produced %0d responses instead of %0d", i,
                  rsp_count - rsp_before, rsp_exp);
      end
      if (t_read[i]) begin
         kind = "read";
      end else begin
         kind = "write";
      end
      if (err_count == errs_before) begin
         verdict = "pass";
      end else begin
         verdict = "FAIL";
      end
      $display("test %0d %0s index %0d latency %0d: %0s", i, kind, t_idx[i], lat, verdict);
   endtask

   //####################
   // Main sequence
   //####################
   initial begin
      build_table();
      cycle_limit = NUM_TESTS * (ACCEPT_LAT + max_bp + 10);
      repeat (2) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      // Idle outputs and a cleared bank
      check_bit("access_out", 1'b0, access_out);
      check_bit("wait_out", 1'b0, wait_out);
      check_regs("spi_regs", '0, spi_regs);
      for (int i = 0; i < NUM_TESTS; i++) begin
         run_entry(i);
      end
      $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, check_count, err_count);
      if (err_count == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* sim.f */
spi_pkg.sv
spi_master_io.sv
spi_master.sv
spi_slave_io.sv
spi_slave.sv
spi_loopback.sv
spi_loopback_assertions.sv
spi_loopback_tb.sv

/* run_sim.sh */
#!/bin/bash
# Build and run the SPI loopback simulation with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f sim.f --top-module spi_loopback_tb

./obj_dir/Vspi_loopback_tb 2>&1 | tee sim.log

if grep -q "Checks failed" sim.log; then
   echo "Simulation reported a failure"
   exit 1
fi
echo "Simulation finished without failures"
